/* logic/llc_pkg.sv */
package llc_pkg;

    localparam int LLC_WAYS       = 4;
    localparam int LLC_SETS       = 16;
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int ADDR_BITS      = 16;
    localparam int SET_BITS       = 4;
    localparam int TAG_BITS       = ADDR_BITS - SET_BITS;
    localparam int WAY_BITS       = 2;

    typedef logic [WORDS_PER_LINE*WORD_BITS-1:0] line_t;
    typedef logic [ADDR_BITS-1:0]                line_addr_t; // {tag, set}
    typedef logic [SET_BITS-1:0]                 llc_set_t;
    typedef logic [TAG_BITS-1:0]                 llc_tag_t;
    typedef logic [WAY_BITS-1:0]                 llc_way_t;

    typedef enum logic [1:0] {
        LLC_INVALID = 2'b00,
        LLC_VALID   = 2'b01,
        LLC_DIRTY   = 2'b10
    } llc_state_t;

    typedef struct packed {
        llc_state_t state;
        llc_tag_t   tag;
        line_t      line;
    } llc_entry_t;

    typedef struct packed {
        logic       is_write;
        line_addr_t addr;
        line_t      line;
    } llc_req_t;

    // writebacks carry the victim line, fills leave line unused
    typedef struct packed {
        logic       is_write;
        line_addr_t addr;
        line_t      line;
    } llc_mem_req_t;

    // adjacent phases differ in one bit
    typedef enum logic [2:0] {
        PH_DECODE  = 3'b000,
        PH_READ    = 3'b001,
        PH_LOOKUP  = 3'b011,
        PH_PROCESS = 3'b010,
        PH_UPDATE  = 3'b110
    } llc_phase_t;

endpackage

/* logic/llc_fsm.sv */
`timescale 1ns/1ps

module llc_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid_i,
    input  logic                sweep_valid_i,
    input  logic                sweep_flush_i,
    input  logic                process_done_i,
    input  logic                last_set_i,
    output llc_pkg::llc_phase_t phase_o,
    output logic                sweeping_o,
    output logic                flush_mode_o,
    output logic                take_req_o,
    output logic                req_ready_o,
    output logic                sweep_ready_o,
    output logic                sweep_done_o
);

    llc_pkg::llc_phase_t next_phase;
    logic                rst_stall;
    logic                take_sweep;

    assign sweep_ready_o = (phase_o == llc_pkg::PH_DECODE) && !sweeping_o;
    assign take_sweep    = sweep_valid_i && sweep_ready_o;
    // a waiting sweep command wins over requests
    assign req_ready_o   = sweep_ready_o && !sweep_valid_i && !rst_stall;
    assign take_req_o    = req_valid_i && req_ready_o;
    assign sweep_done_o  = (phase_o == llc_pkg::PH_UPDATE) && sweeping_o && last_set_i;

    always_comb begin
        next_phase = phase_o;
        case (phase_o)
            llc_pkg::PH_DECODE: begin
                if (sweeping_o || take_sweep || take_req_o) begin
                    next_phase = llc_pkg::PH_READ;
                end
            end
            llc_pkg::PH_READ:    next_phase = llc_pkg::PH_LOOKUP;
            llc_pkg::PH_LOOKUP:  next_phase = llc_pkg::PH_PROCESS;
            llc_pkg::PH_PROCESS: begin
                if (process_done_i) begin
                    next_phase = llc_pkg::PH_UPDATE;
                end
            end
            default:             next_phase = llc_pkg::PH_DECODE; // UPDATE
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase_o      <= llc_pkg::PH_DECODE;
            sweeping_o   <= 1'b0;
            flush_mode_o <= 1'b0;
        end else begin
            phase_o <= next_phase;
            if (take_sweep) begin
                sweeping_o   <= 1'b1;
                flush_mode_o <= sweep_flush_i;
            end else if (sweep_done_o) begin
                sweeping_o <= 1'b0;
            end
        end
    end

    // requests stay blocked until a reset sweep has cleared every set
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_stall <= 1'b1;
        end else if (sweep_done_o && !flush_mode_o) begin
            rst_stall <= 1'b0;
        end
    end

    // the way buffer reports done only while PROCESS waits for it
    assert property (@(posedge clk) disable iff (!rst)
        process_done_i |-> phase_o == llc_pkg::PH_PROCESS);

endmodule

/* logic/llc_sweep_counter.sv */
`timescale 1ns/1ps

module llc_sweep_counter (
    input  logic                clk,
    input  logic                rst,
    input  llc_pkg::llc_phase_t phase_i,
    input  logic                sweeping_i,
    output llc_pkg::llc_set_t   sweep_set_o,
    output logic                last_set_o
);

    assign last_set_o = sweep_set_o == llc_pkg::llc_set_t'(llc_pkg::LLC_SETS - 1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sweep_set_o <= '0;
        end else if (!sweeping_i) begin
            sweep_set_o <= '0; // next sweep starts at set 0
        end else if (phase_i == llc_pkg::PH_UPDATE) begin
            sweep_set_o <= sweep_set_o + 1'b1; // wraps to 0 after the last set
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        phase_i != llc_pkg::PH_UPDATE |=> $stable(sweep_set_o));

endmodule

/* logic/llc_op_register.sv */
`timescale 1ns/1ps

module llc_op_register (
    input  logic              clk,
    input  logic              rst,
    input  logic              take_req_i,
    input  llc_pkg::llc_req_t req_i,
    input  logic              sweeping_i,
    input  llc_pkg::llc_set_t sweep_set_i,
    output llc_pkg::llc_set_t cur_set_o,
    output llc_pkg::llc_tag_t cur_tag_o,
    output llc_pkg::llc_req_t cur_req_o
);

    // held from DECODE until the next request is taken
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cur_req_o <= '0;
        end else if (take_req_i) begin
            cur_req_o <= req_i;
        end
    end

    assign cur_tag_o = cur_req_o.addr[llc_pkg::ADDR_BITS-1:llc_pkg::SET_BITS];

    // sweeps walk the counter, requests use their own set bits
    assign cur_set_o = sweeping_i ? sweep_set_i : cur_req_o.addr[llc_pkg::SET_BITS-1:0];

endmodule

/* logic/llc_tag_data_store.sv */
`timescale 1ns/1ps

module llc_tag_data_store (
    input  logic                                      clk,
    input  logic                                      rst,
    input  llc_pkg::llc_set_t                         set_i,
    input  logic                                      wr_en_i,
    input  llc_pkg::llc_entry_t [llc_pkg::LLC_WAYS-1:0] wr_entries_i,
    input  llc_pkg::llc_way_t                         wr_evict_way_i,
    output llc_pkg::llc_entry_t [llc_pkg::LLC_WAYS-1:0] rd_entries_o,
    output llc_pkg::llc_way_t                         rd_evict_way_o
);

    llc_pkg::llc_entry_t [llc_pkg::LLC_WAYS-1:0] entries [llc_pkg::LLC_SETS];
    llc_pkg::llc_way_t                         evict_ways [llc_pkg::LLC_SETS];

    assign rd_entries_o   = entries[set_i];
    assign rd_evict_way_o = evict_ways[set_i];

    // whole set written at once
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            entries[set_i] <= wr_entries_i;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < llc_pkg::LLC_SETS; s++) begin
                evict_ways[s] <= '0;
            end
        end else if (wr_en_i) begin
            evict_ways[set_i] <= wr_evict_way_i;
        end
    end

endmodule

/* logic/llc_way_buffer.sv */
`timescale 1ns/1ps

module llc_way_buffer (
    input  logic                                      clk,
    input  logic                                      rst,
    input  llc_pkg::llc_phase_t                       phase_i,
    input  logic                                      sweeping_i,
    input  logic                                      flush_mode_i,
    input  logic                                      take_req_i,
    input  llc_pkg::llc_set_t                         cur_set_i,
    input  llc_pkg::llc_tag_t                         cur_tag_i,
    input  llc_pkg::llc_req_t                         cur_req_i,
    input  llc_pkg::llc_entry_t [llc_pkg::LLC_WAYS-1:0] rd_entries_i,
    input  llc_pkg::llc_way_t                         rd_evict_way_i,
    input  logic                                      mem_req_ready_i,
    input  logic                                      mem_rsp_valid_i,
    input  llc_pkg::line_t                            mem_rsp_line_i,
    input  logic                                      rsp_ready_i,
    output logic                                      process_done_o,
    output logic                                      mem_req_valid_o,
    output llc_pkg::llc_mem_req_t                     mem_req_o,
    output logic                                      mem_rsp_ready_o,
    output logic                                      rsp_valid_o,
    output llc_pkg::line_t                            rsp_line_o,
    output logic                                      wr_en_o,
    output llc_pkg::llc_entry_t [llc_pkg::LLC_WAYS-1:0] wr_entries_o,
    output llc_pkg::llc_way_t                         wr_evict_way_o
);

    typedef enum logic [2:0] {ST_IDLE, ST_WB, ST_FILL, ST_WAIT, ST_RSP, ST_DONE} step_t;

    localparam llc_pkg::llc_way_t LAST_WAY = llc_pkg::llc_way_t'(llc_pkg::LLC_WAYS - 1);

    llc_pkg::llc_entry_t [llc_pkg::LLC_WAYS-1:0] buf_q;
    llc_pkg::llc_way_t                         evict_q;
    llc_pkg::llc_way_t                         way_q; // hit, victim or flush way
    logic                                      hit_q;
    step_t                                     step;
    logic [llc_pkg::LLC_WAYS-1:0]              hit_vec;
    logic [llc_pkg::LLC_WAYS-1:0]              free_vec;
    llc_pkg::llc_way_t                         hit_way;
    llc_pkg::llc_way_t                         free_way;
    logic                                      cur_dirty;
    logic                                      sweep_clear;

    always_comb begin
        hit_way  = '0;
        free_way = '0;
        for (int w = llc_pkg::LLC_WAYS - 1; w >= 0; w--) begin // lowest way wins
            hit_vec[w]  = buf_q[w].state != llc_pkg::LLC_INVALID && buf_q[w].tag == cur_tag_i;
            free_vec[w] = buf_q[w].state == llc_pkg::LLC_INVALID;
            if (hit_vec[w]) hit_way = llc_pkg::llc_way_t'(w);
            if (free_vec[w]) free_way = llc_pkg::llc_way_t'(w);
        end
    end

    assign cur_dirty = buf_q[way_q].state == llc_pkg::LLC_DIRTY;
    // reset sweep at once, flush after the last way is clean
    assign sweep_clear = sweeping_i && (!flush_mode_i || (!cur_dirty && way_q == LAST_WAY));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            step    <= ST_IDLE;
            evict_q <= '0;
            way_q   <= '0;
            hit_q   <= 1'b0;
        end else begin
            if (take_req_i || (sweeping_i && phase_i == llc_pkg::PH_READ)) begin
                step <= ST_IDLE; // a new operation starts
            end
            if (phase_i == llc_pkg::PH_READ) begin
                evict_q <= rd_evict_way_i;
            end
            if (phase_i == llc_pkg::PH_LOOKUP) begin
                hit_q <= |hit_vec;
                if (sweeping_i) begin
                    way_q <= '0;
                end else if (|hit_vec) begin
                    way_q <= hit_way;
                end else if (|free_vec) begin
                    way_q <= free_way;
                end else begin
                    way_q   <= evict_q;
                    evict_q <= evict_q + 1'b1; // round robin
                end
            end
            if (phase_i == llc_pkg::PH_PROCESS) begin
                case (step)
                    ST_IDLE: begin
                        if (sweep_clear) begin
                            step <= ST_DONE;
                            if (!flush_mode_i) evict_q <= '0;
                        end else if (sweeping_i) begin
                            if (cur_dirty) step <= ST_WB;
                            else way_q <= way_q + 1'b1;
                        end else if (!hit_q && cur_dirty) begin
                            step <= ST_WB; // dirty victim first
                        end else if (cur_req_i.is_write) begin
                            step <= ST_DONE;
                        end else begin
                            step <= hit_q ? ST_RSP : ST_FILL;
                        end
                    end
                    ST_WB:   if (mem_req_ready_i) step <= ST_IDLE;
                    ST_FILL: if (mem_req_ready_i) step <= ST_WAIT;
                    ST_WAIT: if (mem_rsp_valid_i) step <= ST_RSP;
                    ST_RSP:  if (rsp_ready_i) step <= ST_DONE;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (phase_i == llc_pkg::PH_READ) begin
            buf_q <= rd_entries_i;
        end else if (phase_i == llc_pkg::PH_PROCESS) begin
            case (step)
                ST_IDLE: begin
                    if (sweep_clear) begin
                        for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
                            buf_q[w].state <= llc_pkg::LLC_INVALID;
                        end
                    end else if (!sweeping_i && cur_req_i.is_write && (hit_q || !cur_dirty)) begin
                        buf_q[way_q] <= '{state: llc_pkg::LLC_DIRTY, tag: cur_tag_i,
                                          line: cur_req_i.line};
                    end
                end
                ST_WB: begin
                    if (mem_req_ready_i) buf_q[way_q].state <= llc_pkg::LLC_VALID;
                end
                ST_WAIT: begin
                    if (mem_rsp_valid_i) begin
                        buf_q[way_q] <= '{state: llc_pkg::LLC_VALID, tag: cur_tag_i,
                                          line: mem_rsp_line_i};
                    end
                end
                default: ;
            endcase
        end
    end

    assign mem_req_valid_o = step == ST_WB || step == ST_FILL;
    assign mem_req_o = '{is_write: step == ST_WB,
                         addr: (step == ST_WB) ? {buf_q[way_q].tag, cur_set_i} : cur_req_i.addr,
                         line: buf_q[way_q].line};
    assign mem_rsp_ready_o = step == ST_WAIT;
    assign rsp_valid_o     = step == ST_RSP;
    assign rsp_line_o      = buf_q[way_q].line;
    assign process_done_o  = phase_i == llc_pkg::PH_PROCESS && step == ST_DONE;

    assign wr_en_o        = phase_i == llc_pkg::PH_UPDATE;
    assign wr_entries_o   = buf_q;
    assign wr_evict_way_o = evict_q;

    assert property (@(posedge clk) disable iff (!rst)
        (phase_i == llc_pkg::PH_LOOKUP && !sweeping_i) |-> $onehot0(hit_vec));

endmodule

/* logic/llc_top.sv */
`timescale 1ns/1ps

module llc_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid_i,
    input  llc_pkg::llc_req_t     req_i,
    output logic                  req_ready_o,
    input  logic                  sweep_valid_i,
    input  logic                  sweep_flush_i,
    output logic                  sweep_ready_o,
    output logic                  mem_req_valid_o,
    output llc_pkg::llc_mem_req_t mem_req_o,
    input  logic                  mem_req_ready_i,
    input  logic                  mem_rsp_valid_i,
    input  llc_pkg::line_t        mem_rsp_line_i,
    output logic                  mem_rsp_ready_o,
    output logic                  rsp_valid_o,
    output llc_pkg::line_t        rsp_line_o,
    input  logic                  rsp_ready_i,
    output logic                  sweep_done_o
);

    llc_pkg::llc_phase_t                       phase;
    logic                                      sweeping;
    logic                                      flush_mode;
    logic                                      take_req;
    logic                                      process_done;
    logic                                      last_set;
    llc_pkg::llc_set_t                         sweep_set;
    llc_pkg::llc_set_t                         cur_set;
    llc_pkg::llc_tag_t                         cur_tag;
    llc_pkg::llc_req_t                         cur_req;
    llc_pkg::llc_entry_t [llc_pkg::LLC_WAYS-1:0] rd_entries;
    llc_pkg::llc_way_t                         rd_evict_way;
    logic                                      wr_en;
    llc_pkg::llc_entry_t [llc_pkg::LLC_WAYS-1:0] wr_entries;
    llc_pkg::llc_way_t                         wr_evict_way;

    llc_fsm fsm_u (
        .clk(clk), .rst(rst),
        .req_valid_i(req_valid_i), .sweep_valid_i(sweep_valid_i),
        .sweep_flush_i(sweep_flush_i), .process_done_i(process_done),
        .last_set_i(last_set), .phase_o(phase), .sweeping_o(sweeping),
        .flush_mode_o(flush_mode), .take_req_o(take_req), .req_ready_o(req_ready_o),
        .sweep_ready_o(sweep_ready_o), .sweep_done_o(sweep_done_o)
    );

    llc_sweep_counter sweep_counter_u (
        .clk(clk), .rst(rst), .phase_i(phase), .sweeping_i(sweeping),
        .sweep_set_o(sweep_set), .last_set_o(last_set)
    );

    llc_op_register op_register_u (
        .clk(clk), .rst(rst), .take_req_i(take_req), .req_i(req_i),
        .sweeping_i(sweeping), .sweep_set_i(sweep_set),
        .cur_set_o(cur_set), .cur_tag_o(cur_tag), .cur_req_o(cur_req)
    );

    llc_tag_data_store store_u (
        .clk(clk), .rst(rst), .set_i(cur_set), .wr_en_i(wr_en),
        .wr_entries_i(wr_entries), .wr_evict_way_i(wr_evict_way),
        .rd_entries_o(rd_entries), .rd_evict_way_o(rd_evict_way)
    );

    llc_way_buffer way_buffer_u (
        .clk(clk), .rst(rst), .phase_i(phase), .sweeping_i(sweeping),
        .flush_mode_i(flush_mode), .take_req_i(take_req), .cur_set_i(cur_set),
        .cur_tag_i(cur_tag), .cur_req_i(cur_req), .rd_entries_i(rd_entries),
        .rd_evict_way_i(rd_evict_way), .mem_req_ready_i(mem_req_ready_i),
        .mem_rsp_valid_i(mem_rsp_valid_i), .mem_rsp_line_i(mem_rsp_line_i),
        .rsp_ready_i(rsp_ready_i), .process_done_o(process_done),
        .mem_req_valid_o(mem_req_valid_o), .mem_req_o(mem_req_o),
        .mem_rsp_ready_o(mem_rsp_ready_o), .rsp_valid_o(rsp_valid_o),
        .rsp_line_o(rsp_line_o), .wr_en_o(wr_en), .wr_entries_o(wr_entries),
        .wr_evict_way_o(wr_evict_way)
    );

endmodule

/* tests/llc_tb.sv */
`timescale 1ns/1ps

module llc_tb;

    logic                  clk;
    logic                  rst;
    logic                  req_valid_i;
    llc_pkg::llc_req_t     req_i;
    logic                  req_ready_o;
    logic                  sweep_valid_i;
    logic                  sweep_flush_i;
    logic                  sweep_ready_o;
    logic                  mem_req_valid_o;
    llc_pkg::llc_mem_req_t mem_req_o;
    logic                  mem_req_ready_i;
    logic                  mem_rsp_valid_i;
    llc_pkg::line_t        mem_rsp_line_i;
    logic                  mem_rsp_ready_o;
    logic                  rsp_valid_o;
    llc_pkg::line_t        rsp_line_o;
    logic                  rsp_ready_i;
    logic                  sweep_done_o;

    integer seed = 32'h9c21;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int cycles = 0;
    int done_count = 0;
    logic bp_on = 1'b0; // random back-pressure on rsp and mem_req
    logic rsp_drop = 1'b0;
    logic mem_pend = 1'b0;
    logic rsp_pend = 1'b0;
    llc_pkg::llc_mem_req_t mem_prev;
    llc_pkg::line_t rsp_prev;

    llc_pkg::line_t mem [llc_pkg::line_addr_t];
    llc_pkg::line_t ref_data [llc_pkg::line_addr_t]; // expected contents per line address
    llc_pkg::line_addr_t rd_addr_q[$];
    llc_pkg::line_addr_t wr_addr_q[$];
    llc_pkg::line_t wr_data_q[$];
    llc_pkg::line_t rsp_q[$];

    // shadow of the tag store
    llc_pkg::llc_tag_t m_tag [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    logic m_valid [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    logic m_dirty [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];
    llc_pkg::llc_way_t m_evict [llc_pkg::LLC_SETS];

    llc_top llc_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 4000) begin
            $display("timeout: the run did not finish within 4000 cycles");
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [159:0] got, input logic [159:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic llc_pkg::line_t mem_default(input llc_pkg::line_addr_t a);
        return {4{a, ~a}};
    endfunction

    function automatic llc_pkg::line_t rand_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // behavioral memory, channel monitors and ready drivers
    always @(negedge clk) begin
        integer rnd;
        if (rst) begin
            // readies first, so the handshakes below see what the next edge sees
            rnd = $random(seed);
            mem_req_ready_i = bp_on ? rnd[0] : 1'b1;
            rsp_ready_i     = bp_on ? rnd[1] : 1'b1;
            if (rsp_drop) begin
                mem_rsp_valid_i = 1'b0;
                rsp_drop = 1'b0;
            end
            if (mem_rsp_valid_i && mem_rsp_ready_o) rsp_drop = 1'b1;
            if (mem_pend && mem_req_valid_o) check("mem_req_o stable", mem_req_o, mem_prev);
            if (mem_req_valid_o && mem_req_ready_i) begin
                if (mem_req_o.is_write) begin
                    mem[mem_req_o.addr] = mem_req_o.line;
                    wr_addr_q.push_back(mem_req_o.addr);
                    wr_data_q.push_back(mem_req_o.line);
                end else begin
                    rd_addr_q.push_back(mem_req_o.addr);
                    mem_rsp_line_i = mem.exists(mem_req_o.addr) ? mem[mem_req_o.addr]
                                                                : mem_default(mem_req_o.addr);
                    mem_rsp_valid_i = 1'b1;
                end
            end
            mem_pend = mem_req_valid_o && !mem_req_ready_i;
            mem_prev = mem_req_o;
            if (rsp_pend && rsp_valid_o) check("rsp_line_o stable", rsp_line_o, rsp_prev);
            if (rsp_valid_o && rsp_ready_i) rsp_q.push_back(rsp_line_o);
            rsp_pend = rsp_valid_o && !rsp_ready_i;
            rsp_prev = rsp_line_o;
            if (sweep_done_o) done_count++;
        end
    end

    task automatic model_access(input logic wr, input llc_pkg::line_addr_t a, output logic wb,
                                output llc_pkg::line_addr_t wb_addr, output logic fill);
        llc_pkg::llc_set_t s;
        llc_pkg::llc_tag_t t;
        int way;
        int hit;
        s = a[llc_pkg::SET_BITS-1:0];
        t = a[llc_pkg::ADDR_BITS-1:llc_pkg::SET_BITS];
        hit = -1;
        way = -1;
        wb = 1'b0;
        fill = 1'b0;
        wb_addr = '0;
        for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t && hit < 0) hit = w;
        end
        if (hit >= 0) begin
            way = hit;
        end else begin
            for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
                if (!m_valid[s][w] && way < 0) way = w; // lowest free way
            end
            if (way < 0) begin
                way = int'(m_evict[s]);
                m_evict[s] = m_evict[s] + 2'd1;
            end
            if (m_valid[s][way] && m_dirty[s][way]) begin
                wb = 1'b1;
                wb_addr = {m_tag[s][way], s};
            end
            fill = !wr;
            m_dirty[s][way] = 1'b0;
        end
        m_valid[s][way] = 1'b1;
        m_tag[s][way] = t;
        if (wr) m_dirty[s][way] = 1'b1;
    endtask

    task automatic wait_req_ready();
        while (!req_ready_o) @(negedge clk);
    endtask

    task automatic access(input logic wr, input llc_pkg::line_addr_t a, input llc_pkg::line_t d);
        logic wb;
        logic fill;
        llc_pkg::line_addr_t wb_addr;
        llc_pkg::line_t exp_line;
        llc_pkg::line_t wb_line;
        int nr;
        int nw;
        nr = rd_addr_q.size();
        nw = wr_addr_q.size();
        exp_line = ref_data.exists(a) ? ref_data[a] : mem_default(a);
        model_access(wr, a, wb, wb_addr, fill);
        wb_line = ref_data.exists(wb_addr) ? ref_data[wb_addr] : mem_default(wb_addr);
        if (wr) ref_data[a] = d;
        @(negedge clk);
        req_valid_i = 1'b1;
        req_i = '{is_write: wr, addr: a, line: d};
        wait_req_ready();
        @(negedge clk);
        req_valid_i = 1'b0;
        if (!wr) begin
            while (rsp_q.size() == 0) @(negedge clk);
            check("rsp_line_o", rsp_q.pop_front(), exp_line);
        end
        wait_req_ready();
        check("mem read count", rd_addr_q.size() - nr, fill);
        check("mem write count", wr_addr_q.size() - nw, wb);
        if (fill && rd_addr_q.size() > nr) check("mem read addr", rd_addr_q[nr], a);
        if (wb && wr_addr_q.size() > nw) begin
            check("mem write addr", wr_addr_q[nw], wb_addr);
            check("mem write line", wr_data_q[nw], wb_line);
        end
    endtask

    task automatic sweep(input logic flush);
        int n;
        n = done_count;
        @(negedge clk);
        sweep_valid_i = 1'b1;
        sweep_flush_i = flush;
        while (!sweep_ready_o) @(negedge clk);
        @(negedge clk);
        sweep_valid_i = 1'b0;
        check("sweep_ready_o during sweep", sweep_ready_o, 0);
        while (!sweep_ready_o) @(negedge clk);
        @(negedge clk);
        check("sweep_done_o pulses", done_count - n, 1);
        for (int s = 0; s < llc_pkg::LLC_SETS; s++) begin
            for (int w = 0; w < llc_pkg::LLC_WAYS; w++) m_valid[s][w] = 1'b0;
            if (!flush) m_evict[s] = '0;
        end
    endtask

    task automatic reset_stall();
        check("req_ready_o", req_ready_o, 0);
        check("rsp_valid_o", rsp_valid_o, 0);
        check("mem_req_valid_o", mem_req_valid_o, 0);
        check("mem_rsp_ready_o", mem_rsp_ready_o, 0);
        check("sweep_done_o", sweep_done_o, 0);
        check("sweep_ready_o", sweep_ready_o, 1);
        req_valid_i = 1'b1;
        req_i = '{is_write: 1'b0, addr: 16'h0001, line: '0};
        repeat (10) begin
            @(negedge clk);
            check("req_ready_o stalled", req_ready_o, 0);
        end
        req_valid_i = 1'b0;
        sweep(1'b0);
        check("req_ready_o after sweep", req_ready_o, 1);
        tests++;
        $display("test reset_stall finished, errors %0d", errors);
    endtask

    task automatic read_miss_then_hit();
        access(1'b0, 16'h0123, '0);
        access(1'b0, 16'h0123, '0);
        tests++;
        $display("test read_miss_hit finished, errors %0d", errors);
    endtask

    task automatic write_then_read();
        access(1'b1, 16'h0457, rand_line()); // miss into a free way
        access(1'b0, 16'h0457, '0);
        access(1'b1, 16'h0457, rand_line()); // hit
        access(1'b0, 16'h0457, '0);
        tests++;
        $display("test write finished, errors %0d", errors);
    endtask

    task automatic eviction();
        for (int t = 1; t <= 5; t++) access(1'b1, {12'(t), 4'h5}, rand_line());
        access(1'b0, 16'h0015, '0); // evicted line comes back from memory
        tests++;
        $display("test eviction finished, errors %0d", errors);
    endtask

    task automatic flush_dirty_lines();
        llc_pkg::line_addr_t exp_q[$];
        llc_pkg::line_addr_t gone[$];
        int nw;
        int idx;
        for (int s = 0; s < llc_pkg::LLC_SETS; s++) begin
            for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
                if (m_valid[s][w] && m_dirty[s][w]) exp_q.push_back({m_tag[s][w], 4'(s)});
            end
        end
        gone = exp_q;
        nw = wr_addr_q.size();
        sweep(1'b1);
        check("flush write count", wr_addr_q.size() - nw, exp_q.size());
        for (int i = nw; i < wr_addr_q.size(); i++) begin
            idx = -1;
            foreach (exp_q[j]) if (exp_q[j] == wr_addr_q[i]) idx = j;
            if (idx < 0) begin
                errors++;
                $display("flush wrote back address %h, which holds no dirty line", wr_addr_q[i]);
            end else begin
                check("flush write line", wr_data_q[i], ref_data[wr_addr_q[i]]);
                exp_q.delete(idx);
            end
        end
        foreach (gone[i]) access(1'b0, gone[i], '0);
        tests++;
        $display("test flush finished, errors %0d", errors);
    endtask

    task automatic back_pressure();
        bp_on = 1'b1;
        access(1'b0, 16'h0a3c, '0);
        access(1'b0, 16'h0a3c, '0);
        for (int t = 6; t <= 10; t++) access(1'b1, {12'(t), 4'h5}, rand_line());
        access(1'b0, 16'h0065, '0);
        bp_on = 1'b0;
        tests++;
        $display("test back_pressure finished, errors %0d", errors);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        req_valid_i = 1'b0;
        req_i = '0;
        sweep_valid_i = 1'b0;
        sweep_flush_i = 1'b0;
        mem_req_ready_i = 1'b1;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_line_i = '0;
        rsp_ready_i = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        reset_stall();
        read_miss_then_hit();
        write_then_read();
        eviction();
        flush_dirty_lines();
        back_pressure();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* llc_top.f */
logic/llc_pkg.sv
logic/llc_fsm.sv
logic/llc_sweep_counter.sv
logic/llc_op_register.sv
logic/llc_tag_data_store.sv
logic/llc_way_buffer.sv
logic/llc_top.sv
tests/llc_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the llc testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module llc_tb -o llc_sim -f llc_top.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/llc_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
exit 1
